/* source/sdram_pkg.sv */
`default_nettype none

package sdram_pkg;

	// client word address split
	localparam int bank_w = 2;
	localparam int row_w = 12;
	localparam int col_w = 8;
	localparam int addr_w = bank_w + row_w + col_w;
	localparam int data_w = 16;

	// {bank, row, col}, bank on top
	typedef logic [addr_w-1:0] sdram_addr_t;
	typedef logic [data_w-1:0] sdram_data_t;
	// one enable per byte lane
	typedef logic [data_w/8-1:0] byte_en_t;

	// encoding is the pin pattern {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		cmd_nop       = 4'b1111,
		cmd_active    = 4'b0011,
		cmd_read      = 4'b0101,
		cmd_write     = 4'b0100,
		cmd_precharge = 4'b0010,
		cmd_refresh   = 4'b0001,
		cmd_mode      = 4'b0000
	} sdram_cmd_t;

	typedef enum logic [3:0] {
		st_init_wait,
		st_precharge_all,
		st_init_refresh,
		st_init_gap,
		st_mode,
		st_idle,
		st_activate,
		st_rcd,
		st_read,
		st_cas_wait,
		st_capture,
		st_write,
		st_write_recover,
		st_refresh,
		st_refresh_gap
	} ctrl_state_t;

	// CL3, burst length 1, sequential
	localparam int cas_latency = 3;
	localparam logic [row_w-1:0] mode_word = 12'h030;
	localparam int init_refresh_count = 8;
	// tRP and tRC in cycles
	localparam int precharge_gap_cycles = 2;
	localparam int refresh_gap_cycles = 6;
	// write recovery plus auto precharge
	localparam int write_recover_cycles = 4;
	// A10 selects auto precharge / all banks
	localparam int ap_bit = 10;

endpackage

`default_nettype wire

/* source/sdram_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module sdram_arbiter
	import sdram_pkg::*;
(
	input  wire              sys_clk,
	input  wire              rstn,

	// client 0
	input  wire              c0_valid,
	output logic             c0_ready,
	input  wire              c0_write,
	input  wire sdram_addr_t c0_addr,
	input  wire sdram_data_t c0_wdata,
	input  wire byte_en_t    c0_be,
	output logic             c0_rvalid,
	output sdram_data_t      c0_rdata,

	// client 1
	input  wire              c1_valid,
	output logic             c1_ready,
	input  wire              c1_write,
	input  wire sdram_addr_t c1_addr,
	input  wire sdram_data_t c1_wdata,
	input  wire byte_en_t    c1_be,
	output logic             c1_rvalid,
	output sdram_data_t      c1_rdata,

	// toward the controller
	output logic             req_valid,
	input  wire              req_ready,
	output logic             req_write,
	output sdram_addr_t      req_addr,
	output sdram_data_t      req_wdata,
	output byte_en_t         req_be,
	input  wire              rsp_valid,
	input  wire sdram_data_t rsp_rdata
);

	// index of the client that won the previous grant
	logic last_grant;
	// current winner, 1 selects client 1
	logic sel;
	// client that owns the read in flight
	logic rsp_owner;
	logic accept;

	// round robin, the idle side never blocks the other
	always_comb begin
		if (c0_valid && c1_valid)
			sel = ~last_grant;
		else
			sel = c1_valid;
	end

	// request path stays combinational
	assign req_valid = c0_valid | c1_valid;
	assign req_write = sel ? c1_write : c0_write;
	assign req_addr  = sel ? c1_addr  : c0_addr;
	assign req_wdata = sel ? c1_wdata : c0_wdata;
	assign req_be    = sel ? c1_be    : c0_be;

	// loser sees ready low and holds its request
	assign c0_ready = req_ready && c0_valid && !sel;
	assign c1_ready = req_ready && c1_valid && sel;

	assign accept = req_valid && req_ready;

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			last_grant <= 1'b1;
			rsp_owner <= 1'b0;
		end else if (accept) begin
			last_grant <= sel;
			// only one access in flight, so one owner register is enough
			if (!req_write)
				rsp_owner <= sel;
		end
	end

	// response pulse goes to the owner only
	assign c0_rvalid = rsp_valid && !rsp_owner;
	assign c1_rvalid = rsp_valid && rsp_owner;
	assign c0_rdata = rsp_rdata;
	assign c1_rdata = rsp_rdata;

	// grant is exclusive
	assert property (@(posedge sys_clk) disable iff (!rstn)
		!(c0_ready && c1_ready));

endmodule

`default_nettype wire

/* source/sdram_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module sdram_controller
	import sdram_pkg::*;
#(
	parameter int init_wait_cycles = 10000,
	parameter int refresh_interval = 390
) (
	input  wire                sys_clk,
	input  wire                rstn,

	// request port
	input  wire                req_valid,
	output logic               req_ready,
	input  wire                req_write,
	input  wire sdram_addr_t   req_addr,
	input  wire sdram_data_t   req_wdata,
	input  wire byte_en_t      req_be,
	output logic               rsp_valid,
	output sdram_data_t        rsp_rdata,

	// sdram pins
	output logic               cs_n,
	output logic               ras_n,
	output logic               cas_n,
	output logic               we_n,
	output logic [bank_w-1:0]  ba,
	output logic [row_w-1:0]   sa,
	output byte_en_t           dqm,
	output sdram_data_t        dq_out,
	output logic               dq_oe,
	input  wire sdram_data_t   dq_in
);

	// wide enough for the power-up wait and every short gap
	localparam int wait_w = $clog2(init_wait_cycles + 16);
	localparam int ref_w = $clog2(refresh_interval + 1);
	localparam int iref_w = $clog2(init_refresh_count + 1);

	ctrl_state_t state;
	logic [wait_w-1:0] wait_cnt;
	logic [ref_w-1:0] ref_cnt;
	logic [iref_w-1:0] init_ref_cnt;
	logic refresh_due;
	logic accept;
	sdram_cmd_t cmd;

	// request held for the whole access
	logic lat_write;
	sdram_addr_t lat_addr;
	sdram_data_t lat_wdata;
	byte_en_t lat_be;
	logic [bank_w-1:0] lat_bank;
	logic [row_w-1:0] lat_row;
	logic [col_w-1:0] lat_col;

	assign lat_bank = lat_addr[addr_w-1 -: bank_w];
	assign lat_row = lat_addr[col_w +: row_w];
	assign lat_col = lat_addr[0 +: col_w];

	// refresh timer
	assign refresh_due = (ref_cnt >= ref_w'(refresh_interval));

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn)
			ref_cnt <= '0;
		else if (state == st_refresh || state == st_init_refresh)
			// counts cycles since the refresh command itself
			ref_cnt <= ref_w'(1);
		else if (!refresh_due)
			// holds once due so an access cannot wrap it
			ref_cnt <= ref_cnt + 1'b1;
	end

	// refreshes issued during power-up
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn)
			init_ref_cnt <= '0;
		else if (state == st_init_refresh)
			init_ref_cnt <= init_ref_cnt + 1'b1;
	end

	// accept only in idle and never ahead of a due refresh
	assign req_ready = (state == st_idle) && !refresh_due;
	assign accept = req_valid && req_ready;

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			lat_write <= req_write;
			lat_addr <= req_addr;
			lat_wdata <= req_wdata;
			lat_be <= req_be;
		end
	end

	// main FSM, wait_cnt loaded on entry to each timed state
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			state <= st_init_wait;
			wait_cnt <= wait_w'(init_wait_cycles - 1);
		end else begin
			case (state)
				st_init_wait:
					if (wait_cnt == '0)
						state <= st_precharge_all;
					else
						wait_cnt <= wait_cnt - 1'b1;
				st_precharge_all: begin
					state <= st_init_gap;
					wait_cnt <= wait_w'(precharge_gap_cycles - 1);
				end
				st_init_refresh: begin
					state <= st_init_gap;
					wait_cnt <= wait_w'(refresh_gap_cycles - 1);
				end
				st_init_gap:
					if (wait_cnt != '0)
						wait_cnt <= wait_cnt - 1'b1;
					else if (init_ref_cnt == iref_w'(init_refresh_count))
						state <= st_mode;
					else
						state <= st_init_refresh;
				// tMRD is covered by the idle cycle
				st_mode:
					state <= st_idle;
				st_idle:
					if (refresh_due)
						state <= st_refresh;
					else if (accept)
						state <= st_activate;
				st_activate:
					state <= st_rcd;
				st_rcd:
					state <= lat_write ? st_write : st_read;
				st_read: begin
					state <= st_cas_wait;
					wait_cnt <= wait_w'(cas_latency - 1);
				end
				st_cas_wait:
					if (wait_cnt == '0)
						state <= st_capture;
					else
						wait_cnt <= wait_cnt - 1'b1;
				st_capture:
					state <= st_idle;
				st_write: begin
					state <= st_write_recover;
					wait_cnt <= wait_w'(write_recover_cycles - 1);
				end
				st_write_recover:
					if (wait_cnt == '0)
						state <= st_idle;
					else
						wait_cnt <= wait_cnt - 1'b1;
				st_refresh: begin
					state <= st_refresh_gap;
					wait_cnt <= wait_w'(refresh_gap_cycles - 1);
				end
				st_refresh_gap:
					if (wait_cnt == '0)
						state <= st_idle;
					else
						wait_cnt <= wait_cnt - 1'b1;
				default:
					state <= st_idle;
			endcase
		end
	end

	// read data sits on dq_in in the last CAS wait cycle
	always_ff @(posedge sys_clk) begin
		if (state == st_cas_wait && wait_cnt == '0)
			rsp_rdata <= dq_in;
	end

	assign rsp_valid = (state == st_capture);

	// command, bank and address decode
	always_comb begin
		cmd = cmd_nop;
		ba = '0;
		sa = '0;
		case (state)
			st_precharge_all: begin
				cmd = cmd_precharge;
				sa[ap_bit] = 1'b1;
			end
			st_init_refresh, st_refresh:
				cmd = cmd_refresh;
			st_mode: begin
				cmd = cmd_mode;
				sa = mode_word;
			end
			st_activate: begin
				cmd = cmd_active;
				ba = lat_bank;
				sa = lat_row;
			end
			st_read, st_write: begin
				cmd = (state == st_write) ? cmd_write : cmd_read;
				ba = lat_bank;
				sa = row_w'(lat_col);
				// auto precharge
				sa[ap_bit] = 1'b1;
			end
			default:
				cmd = cmd_nop;
		endcase
	end

	assign {cs_n, ras_n, cas_n, we_n} = cmd;

	// mask only the disabled lanes of a write
	assign dqm = (state == st_write) ? ~lat_be : '0;
	assign dq_oe = (state == st_write);
	assign dq_out = dq_oe ? lat_wdata : '0;

	// a due refresh blocks new requests
	assert property (@(posedge sys_clk) disable iff (!rstn)
		refresh_due |-> !req_ready);

	// bus driven only in the write cycle right after tRCD
	assert property (@(posedge sys_clk) disable iff (!rstn)
		dq_oe |-> (state == st_write) && ($past(state) == st_rcd));

endmodule

`default_nettype wire

/* source/sdram_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module sdram_subsystem
	import sdram_pkg::*;
#(
	parameter int init_wait_cycles = 10000,
	parameter int refresh_interval = 390
) (
	input  wire                sys_clk,
	input  wire                rstn,

	// client 0
	input  wire                c0_valid,
	output logic               c0_ready,
	input  wire                c0_write,
	input  wire sdram_addr_t   c0_addr,
	input  wire sdram_data_t   c0_wdata,
	input  wire byte_en_t      c0_be,
	output logic               c0_rvalid,
	output sdram_data_t        c0_rdata,

	// client 1
	input  wire                c1_valid,
	output logic               c1_ready,
	input  wire                c1_write,
	input  wire sdram_addr_t   c1_addr,
	input  wire sdram_data_t   c1_wdata,
	input  wire byte_en_t      c1_be,
	output logic               c1_rvalid,
	output sdram_data_t        c1_rdata,

	// sdram pins, pad handled by the chip wrapper
	output logic               cs_n,
	output logic               ras_n,
	output logic               cas_n,
	output logic               we_n,
	output logic [bank_w-1:0]  ba,
	output logic [row_w-1:0]   sa,
	output byte_en_t           dqm,
	output sdram_data_t        dq_out,
	output logic               dq_oe,
	input  wire sdram_data_t   dq_in
);

	// arbiter to controller
	logic req_valid;
	logic req_ready;
	logic req_write;
	sdram_addr_t req_addr;
	sdram_data_t req_wdata;
	byte_en_t req_be;
	logic rsp_valid;
	sdram_data_t rsp_rdata;

	sdram_arbiter arb_i (
		.sys_clk   (sys_clk),
		.rstn      (rstn),
		.c0_valid  (c0_valid),
		.c0_ready  (c0_ready),
		.c0_write  (c0_write),
		.c0_addr   (c0_addr),
		.c0_wdata  (c0_wdata),
		.c0_be     (c0_be),
		.c0_rvalid (c0_rvalid),
		.c0_rdata  (c0_rdata),
		.c1_valid  (c1_valid),
		.c1_ready  (c1_ready),
		.c1_write  (c1_write),
		.c1_addr   (c1_addr),
		.c1_wdata  (c1_wdata),
		.c1_be     (c1_be),
		.c1_rvalid (c1_rvalid),
		.c1_rdata  (c1_rdata),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_be    (req_be),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata)
	);

	// timing set here for the target clock
	sdram_controller #(
		.init_wait_cycles (init_wait_cycles),
		.refresh_interval (refresh_interval)
	) ctrl_i (
		.sys_clk   (sys_clk),
		.rstn      (rstn),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_be    (req_be),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata),
		.cs_n      (cs_n),
		.ras_n     (ras_n),
		.cas_n     (cas_n),
		.we_n      (we_n),
		.ba        (ba),
		.sa        (sa),
		.dqm       (dqm),
		.dq_out    (dq_out),
		.dq_oe     (dq_oe),
		.dq_in     (dq_in)
	);

endmodule

`default_nettype wire

/* bench/sdram_model.sv */
`timescale 1ns/10ps
`default_nettype none

module sdram_model
	import sdram_pkg::*;
#(
	parameter int refresh_interval = 390
) (
	input  wire               sys_clk,
	input  wire               rstn,
	input  wire               cs_n,
	input  wire               ras_n,
	input  wire               cas_n,
	input  wire               we_n,
	input  wire [bank_w-1:0]  ba,
	input  wire [row_w-1:0]   sa,
	input  wire byte_en_t     dqm,
	input  wire sdram_data_t  dq_out,
	input  wire               dq_oe,
	output sdram_data_t       dq_in,
	output sdram_cmd_t        cmd,
	output logic              proto_fail
);

	// longest access that can hold off a due refresh
	localparam int max_access_cycles = 8;

	// sparse storage, one word per written address
	sdram_data_t mem [sdram_addr_t];
	logic [3:0] bank_open;
	logic [row_w-1:0] open_row [4];
	// read data pipeline
	logic [cas_latency-1:0] rd_v;
	sdram_data_t rd_q [cas_latency];
	// set once the mode register is written
	logic in_service;
	int since_ref;
	sdram_addr_t acc_addr;

	assign cmd = sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});
	// column access goes to the row opened in that bank
	assign acc_addr = {ba, open_row[ba], sa[col_w-1:0]};
	// bus idle unless a read is due this cycle
	assign dq_in = (rd_v[cas_latency-1] === 1'b1) ? rd_q[cas_latency-1] : '0;

	// content of a never written word
	function automatic sdram_data_t fill_word(input sdram_addr_t a);
		return a[15:0] ^ {a[21:16], a[21:12]};
	endfunction

	task report_violation(input string why);
		$display("sdram model: %s at %0t", why, $time);
		proto_fail <= 1'b1;
	endtask

	always @(posedge sys_clk or negedge rstn) begin
		sdram_data_t word;
		if (!rstn) begin
			bank_open <= '0;
			rd_v <= '0;
			in_service <= 1'b0;
			since_ref <= 0;
			proto_fail <= 1'b0;
		end else begin
			// data leaves cas_latency cycles after the read command
			rd_v <= {rd_v[cas_latency-2:0], cmd == cmd_read};
			for (int i = cas_latency - 1; i > 0; i--)
				rd_q[i] <= rd_q[i-1];
			since_ref <= since_ref + 1;
			case (cmd)
				cmd_active: begin
					if (bank_open[ba])
						report_violation("active to a bank that is already open");
					if (in_service && since_ref < refresh_gap_cycles)
						report_violation("active command inside a refresh gap");
					bank_open[ba] <= 1'b1;
					open_row[ba] <= sa;
				end
				cmd_read, cmd_write: begin
					if (!bank_open[ba])
						report_violation("read or write to a closed bank");
					if (!sa[ap_bit])
						report_violation("access without auto precharge");
					// auto precharge closes the bank again
					bank_open[ba] <= 1'b0;
					word = mem.exists(acc_addr) ? mem[acc_addr] : fill_word(acc_addr);
					if (cmd == cmd_write) begin
						if (!dq_oe)
							report_violation("write with the data bus not driven");
						// dqm high masks a lane
						for (int i = 0; i < data_w / 8; i++)
							if (!dqm[i])
								word[8*i +: 8] = dq_out[8*i +: 8];
						mem[acc_addr] = word;
					end
					rd_q[0] <= word;
				end
				cmd_refresh: begin
					if (bank_open != '0)
						report_violation("refresh with a bank still open");
					since_ref <= 0;
				end
				cmd_mode:
					in_service <= 1'b1;
				default: ;
			endcase
			// refresh may slip by one access at most
			if (in_service && cmd != cmd_refresh &&
					since_ref >= refresh_interval + max_access_cycles)
				report_violation("refresh interval exceeded");
		end
	end

endmodule

`default_nettype wire

/* bench/tb_sdram_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_sdram_subsystem
	import sdram_pkg::*;
;

	localparam int tb_init_wait = 40;
	localparam int tb_refresh_interval = 120;
	// cycles any single wait may take
	localparam int wait_limit = 400;

	logic sys_clk;
	logic rstn;

	// client side, index is the client number
	logic [1:0] valid;
	logic [1:0] wr;
	logic [1:0] ready;
	logic [1:0] rvalid;
	sdram_addr_t addr [2];
	sdram_data_t wdata [2];
	byte_en_t be [2];
	sdram_data_t rdata [2];
	logic rd_pending [2];

	// pins
	logic cs_n;
	logic ras_n;
	logic cas_n;
	logic we_n;
	logic [bank_w-1:0] ba;
	logic [row_w-1:0] sa;
	byte_en_t dqm;
	sdram_data_t dq_out;
	sdram_data_t dq_in;
	logic dq_oe;
	sdram_cmd_t pin_cmd;
	logic proto_fail;

	// trace columns
	int tr_client [$];
	logic tr_write [$];
	sdram_addr_t tr_addr [$];
	sdram_data_t tr_data [$];
	byte_en_t tr_be [$];
	sdram_data_t tr_exp [$];

	logic have_last = 1'b0;
	logic last_win = 1'b0;
	logic powerup_ok;

	sdram_subsystem #(
		.init_wait_cycles (tb_init_wait),
		.refresh_interval (tb_refresh_interval)
	) dut_i (
		.sys_clk   (sys_clk),
		.rstn      (rstn),
		.c0_valid  (valid[0]),
		.c0_ready  (ready[0]),
		.c0_write  (wr[0]),
		.c0_addr   (addr[0]),
		.c0_wdata  (wdata[0]),
		.c0_be     (be[0]),
		.c0_rvalid (rvalid[0]),
		.c0_rdata  (rdata[0]),
		.c1_valid  (valid[1]),
		.c1_ready  (ready[1]),
		.c1_write  (wr[1]),
		.c1_addr   (addr[1]),
		.c1_wdata  (wdata[1]),
		.c1_be     (be[1]),
		.c1_rvalid (rvalid[1]),
		.c1_rdata  (rdata[1]),
		.cs_n      (cs_n),
		.ras_n     (ras_n),
		.cas_n     (cas_n),
		.we_n      (we_n),
		.ba        (ba),
		.sa        (sa),
		.dqm       (dqm),
		.dq_out    (dq_out),
		.dq_oe     (dq_oe),
		.dq_in     (dq_in)
	);

	sdram_model #(
		.refresh_interval (tb_refresh_interval)
	) model_i (
		.sys_clk    (sys_clk),
		.rstn       (rstn),
		.cs_n       (cs_n),
		.ras_n      (ras_n),
		.cas_n      (cas_n),
		.we_n       (we_n),
		.ba         (ba),
		.sa         (sa),
		.dqm        (dqm),
		.dq_out     (dq_out),
		.dq_oe      (dq_oe),
		.dq_in      (dq_in),
		.cmd        (pin_cmd),
		.proto_fail (proto_fail)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input sdram_data_t got, input sdram_data_t exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s exp 0x%h got 0x%h", name, exp, got));
	endtask

	task automatic check_cmd(input string name, input sdram_cmd_t got, input sdram_cmd_t exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s exp 0x%h got 0x%h", name, exp, got));
	endtask

	task automatic check_sa(input string name, input logic [row_w-1:0] got,
			input logic [row_w-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s exp 0x%h got 0x%h", name, exp, got));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s exp 0x%h got 0x%h", name, exp, got));
	endtask

	// one operation per line, lines with # skipped
	task automatic read_trace();
		int fd;
		int n;
		int c;
		int w;
		string line;
		sdram_addr_t a;
		sdram_data_t d;
		sdram_data_t e;
		byte_en_t b;
		fd = $fopen("bench/sdram_trace.txt", "r");
		if (fd == 0)
			fail_run("cannot open the trace file bench/sdram_trace.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.substr(0, 0) != "#") begin
				n = $sscanf(line, "%d %d %h %h %h %h", c, w, a, d, b, e);
				if (n != 6)
					fail_run({"malformed trace line: ", line});
				tr_client.push_back(c);
				tr_write.push_back(w != 0);
				tr_addr.push_back(a);
				tr_data.push_back(d);
				tr_be.push_back(b);
				tr_exp.push_back(e);
			end
		end
		$fclose(fd);
	endtask

	// runs every trace line of client n in order
	task automatic drive_client(input int n);
		int t;
		for (int i = 0; i < tr_client.size(); i++) begin
			if (tr_client[i] == n) begin
				valid[n] = 1'b1;
				wr[n] = tr_write[i];
				addr[n] = tr_addr[i];
				wdata[n] = tr_data[i];
				be[n] = tr_be[i];
				// request held until granted
				t = 0;
				@(negedge sys_clk);
				while (!ready[n]) begin
					t++;
					if (t > wait_limit)
						fail_run($sformatf("client %0d request was never accepted", n));
					@(negedge sys_clk);
				end
				@(posedge sys_clk);
				#1;
				valid[n] = 1'b0;
				if (!tr_write[i]) begin
					rd_pending[n] = 1'b1;
					t = 0;
					@(negedge sys_clk);
					while (!rvalid[n]) begin
						t++;
						if (t > wait_limit)
							fail_run($sformatf("client %0d read response never arrived", n));
						@(negedge sys_clk);
					end
					check_data($sformatf("c%0d_rdata", n), rdata[n], tr_exp[i]);
					@(posedge sys_clk);
					#1;
					rd_pending[n] = 1'b0;
				end
			end
		end
	endtask

	// arbitration and response routing
	always @(negedge sys_clk) begin
		if (rstn) begin
			if (rvalid[0] && !rd_pending[0])
				fail_run("read response on client 0 with no read outstanding");
			if (rvalid[1] && !rd_pending[1])
				fail_run("read response on client 1 with no read outstanding");
			if (ready[0] || ready[1]) begin
				// both asking, the previous loser wins
				if (valid[0] && valid[1] && have_last)
					check_bit("c1_ready", ready[1], ~last_win);
				last_win = ready[1];
				have_last = 1'b1;
			end
			if (proto_fail)
				fail_run("SDRAM model saw an illegal command sequence");
		end
	end

	// power-up command order
	initial begin
		sdram_cmd_t exp_cmd;
		int t;
		powerup_ok = 1'b0;
		@(negedge sys_clk);
		check_cmd("cmd", pin_cmd, cmd_nop);
		check_bit("cs_n", cs_n, 1'b1);
		check_bit("dq_oe", dq_oe, 1'b0);
		check_bit("c0_ready", ready[0], 1'b0);
		check_bit("c1_ready", ready[1], 1'b0);
		check_bit("c0_rvalid", rvalid[0], 1'b0);
		check_bit("c1_rvalid", rvalid[1], 1'b0);
		for (int k = 0; k < init_refresh_count + 2; k++) begin
			if (k == 0)
				exp_cmd = cmd_precharge;
			else if (k <= init_refresh_count)
				exp_cmd = cmd_refresh;
			else
				exp_cmd = cmd_mode;
			t = 0;
			@(negedge sys_clk);
			while (pin_cmd == cmd_nop) begin
				if (ready != 2'b00)
					fail_run("client granted before the power-up sequence finished");
				t++;
				if (t > wait_limit)
					fail_run("power-up command never issued");
				@(negedge sys_clk);
			end
			check_cmd("cmd", pin_cmd, exp_cmd);
			// precharge of all banks
			if (k == 0)
				check_bit("sa[10]", sa[ap_bit], 1'b1);
			if (exp_cmd == cmd_mode)
				check_sa("sa", sa, mode_word);
		end
		powerup_ok = 1'b1;
	end

	initial begin
		rstn = 1'b0;
		valid = 2'b00;
		wr = 2'b00;
		for (int k = 0; k < 2; k++) begin
			addr[k] = '0;
			wdata[k] = '0;
			be[k] = '0;
			rd_pending[k] = 1'b0;
		end
		read_trace();
		repeat (5) @(posedge sys_clk);
		#1;
		rstn = 1'b1;
		fork
			drive_client(0);
			drive_client(1);
		join
		// idle bus, refreshes keep running
		repeat (3 * tb_refresh_interval) @(posedge sys_clk);
		if (powerup_ok) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			fail_run("power-up sequence did not complete");
		end
	end

endmodule

`default_nettype wire

/* bench/sdram_trace.txt */
# client op(1=write 0=read) addr(bank,row,col) wdata be expected_rdata
# all values hex except client and op, expected only checked on reads
0 1 000123 1111 3 0000
1 1 2abc10 beef 3 0000
0 1 100123 2222 3 0000
1 1 3fffff cafe 3 0000
0 1 000223 3333 3 0000
1 1 2abc10 0077 2 0000
0 1 000124 4444 3 0000
1 0 2abc10 0000 0 00ef
0 0 000123 0000 0 1111
1 0 3fffff 0000 0 cafe
0 0 100123 0000 0 2222
1 1 200010 1234 3 0000
0 0 000223 0000 0 3333
1 0 200010 0000 0 1234
0 0 000124 0000 0 4444
1 0 2abc10 0000 0 00ef
0 1 000123 aa55 1 0000
0 0 000123 0000 0 1155

/* files.f */
source/sdram_pkg.sv
source/sdram_arbiter.sv
source/sdram_controller.sv
source/sdram_subsystem.sv
bench/sdram_model.sv
bench/tb_sdram_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run from the project root, then scan the log
verilator --binary --timing --assert -f files.f --top-module tb_sdram_subsystem \
	-o sim_sdram > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_sdram > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"
